//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
LINT      = --lint-only --timing -Wall
TOP       = tb_mod_arith
FILELIST  = verilog.f
LOG       = sim.log
BIN       = obj_dir/$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)

run: build
	./$(BIN) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- sim/mod_arith_checker.sv
// Arbitration and completion assertions, bound into the coprocessor top level
`timescale 1ns/1ps
`default_nettype none

module mod_arith_checker
    import ma_pkg::*;
(
    input wire logic       clk,
    input wire logic       rst,
    input wire logic [2:0] arb_valid,
    input wire logic [2:0] arb_ready,
    input wire logic [2:0] arb_rd_valid,
    input wire logic       bank_en,
    input wire logic       bank_we,
    input wire logic       done0_valid,
    input wire ma_addr_t   done0_dst,
    input wire logic       done0_ready,
    input wire logic       done1_valid,
    input wire ma_addr_t   done1_dst,
    input wire logic       done1_ready
);

    int fail_count = 0;    // Failed assertions so far

    ////////////////////
    // Arbiter

    a_one_grant: assert property (@(posedge clk) disable iff (rst) $onehot0(arb_ready))
        else
        begin
            $error("More than one grant in a cycle");
            fail_count++;
        end

    a_grant_pending: assert property (@(posedge clk) disable iff (rst)
        (arb_ready & ~arb_valid) == 3'b000)
        else
        begin
            $error("Grant without a pending request");
            fail_count++;
        end

    // Read data only to the owner of last cycle's read grant
    a_rd_return: assert property (@(posedge clk) disable iff (rst)
        (|arb_rd_valid) |-> ($past(bank_en && !bank_we) && arb_rd_valid == $past(arb_ready)))
        else
        begin
            $error("Read return without a read grant one cycle before");
            fail_count++;
        end

    ////////////////////
    // Completion hold

    a_done0_hold: assert property (@(posedge clk) disable iff (rst)
        done0_valid && !done0_ready |=> done0_valid && $stable(done0_dst))
        else
        begin
            $error("Lane 0 completion dropped or changed before acceptance");
            fail_count++;
        end

    a_done1_hold: assert property (@(posedge clk) disable iff (rst)
        done1_valid && !done1_ready |=> done1_valid && $stable(done1_dst))
        else
        begin
            $error("Lane 1 completion dropped or changed before acceptance");
            fail_count++;
        end

endmodule

bind mod_arith_top mod_arith_checker u_checker
(
    .clk          (clk),
    .rst          (rst),
    .arb_valid    (arb_valid),
    .arb_ready    (arb_ready),
    .arb_rd_valid (arb_rd_valid),
    .bank_en      (bank_en),
    .bank_we      (bank_req.we),
    .done0_valid  (done0_valid),
    .done0_dst    (done0_dst),
    .done0_ready  (done0_ready),
    .done1_valid  (done1_valid),
    .done1_dst    (done1_dst),
    .done1_ready  (done1_ready)
);

`default_nettype wire

//--- sim/tb_mod_arith.sv
// Testbench for the coprocessor top level; run with the file list, prints a summary at the end
`timescale 1ns/1ps
`default_nettype none

`include "ma_cfg.svh"

module tb_mod_arith
    import ma_pkg::*;
;

    localparam int N_ADD   = 8;
    localparam int N_SUB   = 8;
    localparam int N_TESTS = `MA_DEPTH + N_ADD + N_SUB + 10 + 4;  // One per checked word
    localparam int TIMEOUT = N_TESTS * 40 + 200;
    localparam int SEED    = 18674;

    logic      clk;
    logic      rst;
    logic      host_req_valid;
    bank_req_t host_req;
    wire       host_req_ready;
    wire       host_rd_valid;
    ma_word_t  host_rd_data;
    logic      cmd0_valid;
    ma_cmd_t   cmd0;
    wire       cmd0_ready;
    wire       done0_valid;
    ma_addr_t  done0_dst;
    logic      done0_ready;
    logic      cmd1_valid;
    ma_cmd_t   cmd1;
    wire       cmd1_ready;
    wire       done1_valid;
    ma_addr_t  done1_dst;
    logic      done1_ready;

    ma_word_t  shadow [`MA_DEPTH];  // Expected bank contents
    int        errors;
    int        tests;
    int        cycles;

    mod_arith_top DUT (.*);

    ////////////////////
    // Clock and timeout

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT)
        begin
            $display("Timeout after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    ////////////////////
    // Reference and helpers

    function automatic ma_word_t ma_ref(input ma_op_e op, input ma_word_t a,
                                        input ma_word_t b, input ma_word_t m);
        logic [`MA_WIDTH:0] s;      // One bit wider than a word
        if (op == MA_OP_ADD)
            s = ({1'b0, a} + {1'b0, b}) % {1'b0, m};
        else
            s = ({1'b0, a} + {1'b0, m} - {1'b0, b}) % {1'b0, m};
        return s[`MA_WIDTH-1:0];
    endfunction

    function automatic ma_word_t rand_word();
        ma_word_t w;
        for (int i = 0; i < `MA_WIDTH / 32; i++)
            w[i*32 +: 32] = $urandom;
        return w;
    endfunction

    function automatic ma_cmd_t make_cmd(input ma_op_e op, input int sa, input int sb,
                                         input int sm, input int d);
        ma_cmd_t c;
        c.op    = op;
        c.src_a = ma_addr_t'(sa);
        c.src_b = ma_addr_t'(sb);
        c.src_m = ma_addr_t'(sm);
        c.dst   = ma_addr_t'(d);
        return c;
    endfunction

    task automatic check_word(input string name, input ma_word_t exp, input ma_word_t act);
        tests++;
        assert (exp === act)
            $display("Pass %s", name);
        else
        begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // One host access, returns the read word
    task automatic host_access(input logic we, input int addr, input ma_word_t wdata,
                               output ma_word_t rdata);
        @(negedge clk);
        host_req_valid = 1'b1;
        host_req.we    = we;
        host_req.addr  = ma_addr_t'(addr);
        host_req.wdata = wdata;
        #1;
        while (!host_req_ready)     // Lost arbitration, keep request up
        begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        host_req_valid = 1'b0;
        rdata = host_rd_data;       // Return lands one cycle after grant
        if (!we)
        begin
            assert (host_rd_valid)
            else
            begin
                $display("Host read of address %0d returned no data", addr);
                errors++;
            end
        end
    endtask

    task automatic host_write(input int addr, input ma_word_t w);
        ma_word_t unused;
        host_access(1'b1, addr, w, unused);
        shadow[addr] = w;
    endtask

    task automatic read_check(input string name, input int addr);
        ma_word_t w;
        host_access(1'b0, addr, '0, w);
        check_word(name, shadow[addr], w);
    endtask

    // Modulus odd with top bit set, operands reduced below it
    task automatic load_operands(input int base);
        ma_word_t m;
        m = rand_word() | 1;
        m[`MA_WIDTH-1] = 1'b1;
        host_write(base, rand_word() % m);
        host_write(base + 1, rand_word() % m);
        host_write(base + 2, m);
    endtask

    // Issue one command and take its completion, optionally holding it
    task automatic run_cmd(input int lane, input ma_cmd_t c, input int hold);
        ma_addr_t held;
        @(negedge clk);
        if (lane == 0)
        begin
            cmd0_valid = 1'b1;
            cmd0       = c;
        end
        else
        begin
            cmd1_valid = 1'b1;
            cmd1       = c;
        end
        while (!(lane == 0 ? cmd0_ready : cmd1_ready))   // Lane still busy
            @(negedge clk);
        @(negedge clk);             // Taken at the edge in between
        if (lane == 0)
            cmd0_valid = 1'b0;
        else
            cmd1_valid = 1'b0;
        shadow[c.dst] = ma_ref(c.op, shadow[c.src_a], shadow[c.src_b], shadow[c.src_m]);
        while (!(lane == 0 ? done0_valid : done1_valid))
            @(negedge clk);
        held = (lane == 0) ? done0_dst : done1_dst;
        assert (held == c.dst)
        else
        begin
            $display("Fail lane%0d_dst expected %0d actual %0d", lane, c.dst, held);
            errors++;
        end
        repeat (hold)
        begin
            @(negedge clk);
            assert ((lane == 0) ? (done0_valid && done0_dst == held && !cmd0_ready)
                                : (done1_valid && done1_dst == held && !cmd1_ready))
            else
            begin
                $display("Lane %0d completion not held while done_ready was low", lane);
                errors++;
            end
        end
        if (lane == 0)
            done0_ready = 1'b1;
        else
            done1_ready = 1'b1;
        @(negedge clk);
        if (lane == 0)
            done0_ready = 1'b0;
        else
            done1_ready = 1'b0;
    endtask

    ////////////////////
    // Test sequence

    initial
    begin
        void'($urandom(SEED));
        rst            = 1'b1;
        host_req_valid = 1'b0;
        host_req       = '0;
        cmd0_valid     = 1'b0;
        cmd0           = '0;
        done0_ready    = 1'b0;
        cmd1_valid     = 1'b0;
        cmd1           = '0;
        done1_ready    = 1'b0;
        errors         = 0;
        tests          = 0;
        cycles         = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Host memory
        for (int i = 0; i < `MA_DEPTH; i++)
            host_write(i, rand_word());
        for (int i = 0; i < `MA_DEPTH; i++)
            read_check($sformatf("mem_%0d", i), i);

        // Add on lane 0, subtract on lane 1
        for (int i = 0; i < N_ADD; i++)
        begin
            load_operands(0);
            run_cmd(0, make_cmd(MA_OP_ADD, 0, 1, 2, 3), 0);
            read_check($sformatf("add_%0d", i), 3);
        end
        for (int i = 0; i < N_SUB; i++)
        begin
            load_operands(4);
            run_cmd(1, make_cmd(MA_OP_SUB, 4, 5, 6, 7), 0);
            read_check($sformatf("sub_%0d", i), 7);
        end

        // Both lanes at once, host reading the upper half meanwhile
        load_operands(0);
        load_operands(4);
        fork
            run_cmd(0, make_cmd(MA_OP_ADD, 0, 1, 2, 3), 0);
            run_cmd(1, make_cmd(MA_OP_SUB, 4, 5, 6, 7), 0);
            for (int i = 8; i < `MA_DEPTH; i++)
                read_check($sformatf("conc_rd_%0d", i), i);
        join
        read_check("conc_lane0", 3);
        read_check("conc_lane1", 7);

        // Completion back-pressure, then the next command
        load_operands(0);
        run_cmd(0, make_cmd(MA_OP_ADD, 0, 1, 2, 3), 10);
        read_check("bp_held", 3);
        run_cmd(0, make_cmd(MA_OP_SUB, 0, 1, 2, 3), 0);
        read_check("bp_next", 3);

        // Result overwrites src_a, then feeds the next command
        load_operands(0);
        run_cmd(1, make_cmd(MA_OP_ADD, 0, 1, 2, 0), 0);
        run_cmd(0, make_cmd(MA_OP_SUB, 0, 1, 2, 9), 0);
        read_check("alias_first", 0);
        read_check("alias_second", 9);

        errors += DUT.u_checker.fail_count;   // Bound assertion failures
        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verilog
verilog/ma_pkg.sv
verilog/operand_bank.sv
verilog/bank_arbiter.sv
verilog/mod_add_engine.sv
verilog/mod_lane.sv
verilog/mod_arith_top.sv
sim/mod_arith_checker.sv
sim/tb_mod_arith.sv

//--- verilog/bank_arbiter.sv
// Round-robin arbiter for the operand bank; port 0 is the host, ports 1 and 2 the lanes
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter
    import ma_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] req_valid,
    input  bank_req_t  req [3],
    output logic [2:0] req_ready,     // One-hot grant
    output logic [2:0] rd_valid,      // Read return, owner only
    output ma_word_t   rd_data,       // Shared by all requesters
    output logic       bank_en,
    output bank_req_t  bank_req,
    input  ma_word_t   bank_rd_data
);

    logic [1:0] rr_ptr;    // Requester with top priority
    logic [1:0] win;       // Granted requester
    logic       any_req;
    logic [1:0] rd_owner;  // Who gets the read data
    logic       rd_pend;   // A read is returning this cycle

    // Requester k places after base, wrapping at three
    function automatic logic [1:0] rr_index(input logic [1:0] base, input int unsigned k);
        int unsigned sum;
        sum = base + k;
        return (sum >= 3) ? 2'(sum - 3) : 2'(sum);
    endfunction

    ////////////////////
    // Grant selection

    always_comb
    begin
        win     = rr_ptr;
        any_req = 1'b0;
        // Lowest priority first so the highest one lands last
        for (int k = 2; k >= 0; k--)
        begin
            if (req_valid[rr_index(rr_ptr, k)])
            begin
                win     = rr_index(rr_ptr, k);
                any_req = 1'b1;
            end
        end
    end

    assign req_ready = any_req ? (3'b001 << win) : 3'b000;
    assign bank_en   = any_req;
    assign bank_req  = req[win];           // Winner drives the bank

    ////////////////////
    // Pointer and read return

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rr_ptr   <= 2'd0;
            rd_owner <= 2'd0;
            rd_pend  <= 1'b0;
        end
        else
        begin
            if (any_req)
                rr_ptr <= rr_index(win, 1); // Start after the last winner
            rd_owner <= win;
            rd_pend  <= any_req && !req[win].we;
        end
    end

    always_comb
    begin
        rd_valid = 3'b000;
        if (rd_pend)
            rd_valid[rd_owner] = 1'b1;
    end

    assign rd_data = bank_rd_data;      // Bank output, one cycle after grant

endmodule

`default_nettype wire

//--- verilog/ma_cfg.svh
// Word width and bank depth for the coprocessor; include before using the MA_ macros

`ifndef MA_CFG_SVH
`define MA_CFG_SVH

////////////////////
// Datapath

`define MA_WIDTH 64                // Operand width in bits, 256 also works

////////////////////
// Operand bank

`define MA_DEPTH 16                // Words in the shared bank

// Bank address width follows the depth
`define MA_ADDR_W $clog2(`MA_DEPTH)

`endif

//--- verilog/ma_pkg.sv
// Shared types for the modular arithmetic coprocessor; import into every RTL module
`default_nettype none

`include "ma_cfg.svh"

package ma_pkg;

    ////////////////////
    // Data words

    typedef logic [`MA_WIDTH-1:0]  ma_word_t;   // One operand
    typedef logic [`MA_ADDR_W-1:0] ma_addr_t;   // Bank address

    ////////////////////
    // Commands

    typedef enum logic
    {
        MA_OP_ADD = 1'b0,                        // (a + b) mod m
        MA_OP_SUB = 1'b1                         // (a - b) mod m
    } ma_op_e;

    typedef struct packed
    {
        ma_op_e   op;
        ma_addr_t src_a;                         // First operand
        ma_addr_t src_b;                         // Second operand
        ma_addr_t src_m;                         // Modulus
        ma_addr_t dst;                           // Result goes here
    } ma_cmd_t;

    // One access to the operand bank
    typedef struct packed
    {
        logic     we;                            // High for write
        ma_addr_t addr;
        ma_word_t wdata;                         // Ignored on reads
    } bank_req_t;

    ////////////////////
    // Lane sequencer

    typedef enum logic [2:0]
    {
        LANE_IDLE,                               // Waiting for a command
        LANE_RD_A,
        LANE_RD_B,
        LANE_RD_M,
        LANE_RUN,                                // Engine busy
        LANE_WB,                                 // Result write
        LANE_DONE                                // Completion held for host
    } lane_state_e;

endpackage

`default_nettype wire

//--- verilog/mod_add_engine.sv
// Iterative modular add/subtract engine; pulse start with operands and wait for done
`timescale 1ns/1ps
`default_nettype none

`include "ma_cfg.svh"

module mod_add_engine
    import ma_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,    // One-cycle pulse, restarts any run
    input  ma_op_e   op,
    input  ma_word_t op1,
    input  ma_word_t op2,
    input  ma_word_t mod,
    output ma_word_t result,   // Held until the next done
    output logic     done      // One-cycle pulse
);

    localparam int W = `MA_WIDTH;

    ma_word_t add_a;     // Adder inputs
    ma_word_t add_b;
    logic     add_ci;
    ma_word_t rslt;      // Registered adder output
    logic     co;        // Registered carry out
    logic     ci_used;   // Carry in behind rslt

    ma_word_t a_q;       // Fed-back partial result
    ma_word_t p_q;       // Latched modulus
    logic     ci_q;      // Direction of the next correction

    logic     eval;      // rslt is fresh this cycle
    logic     corr;      // Correction operands loaded
    logic     pend;      // An uncorrected wrap sits in rslt
    logic     ovf;
    logic     wrapped;
    logic     finish;

    ////////////////////
    // Registered adder

    // Start bypasses the operand registers so the first sum lands a cycle sooner
    always_comb
    begin
        add_a  = start ? op1 : a_q;
        add_b  = start ? op2 : p_q;             // Modulus on every correction
        add_ci = start ? (op == MA_OP_SUB) : ci_q;
    end

    always_ff @(posedge clk)
    begin
        {co, rslt} <= {1'b0, add_a}
                    + {1'b0, add_b ^ {W{add_ci}}}  // Invert for subtract
                    + {{W{1'b0}}, add_ci};
        ci_used    <= add_ci;
    end

    ////////////////////
    // Range check

    assign ovf     = ci_used ^ co;             // Add carry or subtract borrow
    assign wrapped = pend ^ ovf;               // Second wrap cancels the first
    assign finish  = eval && !wrapped && (rslt < p_q);

    // Operands for the next pass
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            p_q <= mod;
        end
        else if (eval && !finish)
        begin
            a_q <= rslt;
            if (wrapped)
                ci_q <= pend ? ci_used : !ci_used; // Undo the wrap
            else
                ci_q <= 1'b1;                      // Sum not below m, subtract
        end
    end

    ////////////////////
    // Sequencing

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            eval <= 1'b0;
            corr <= 1'b0;
            pend <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            eval <= start || corr;
            corr <= !start && eval && !finish;  // Two cycles per correction
            done <= !start && finish;
            if (start)
                pend <= 1'b0;
            else if (eval && !finish)
                pend <= wrapped;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!start && finish)
            result <= rslt;
    end

endmodule

`default_nettype wire

//--- verilog/mod_arith_top.sv
// Coprocessor top level; operand bank, arbiter and two lanes, host port is requester 0
`timescale 1ns/1ps
`default_nettype none

module mod_arith_top
    import ma_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // Host bank access
    input  logic      host_req_valid,
    input  bank_req_t host_req,
    output logic      host_req_ready,
    output logic      host_rd_valid,
    output ma_word_t  host_rd_data,
    // Lane 0
    input  logic      cmd0_valid,
    input  ma_cmd_t   cmd0,
    output logic      cmd0_ready,
    output logic      done0_valid,
    output ma_addr_t  done0_dst,
    input  logic      done0_ready,
    // Lane 1
    input  logic      cmd1_valid,
    input  ma_cmd_t   cmd1,
    output logic      cmd1_ready,
    output logic      done1_valid,
    output ma_addr_t  done1_dst,
    input  logic      done1_ready
);

    wire logic [2:0] arb_valid;      // Index 0 host, 1 lane 0, 2 lane 1
    wire logic [2:0] arb_ready;
    wire logic [2:0] arb_rd_valid;
    wire bank_req_t  arb_req [3];
    wire ma_word_t   rd_word;        // Shared read data
    wire logic       bank_en;
    wire bank_req_t  bank_req;
    wire ma_word_t   bank_rd_data;

    // Host on requester 0
    assign arb_valid[0]   = host_req_valid;
    assign arb_req[0]     = host_req;
    assign host_req_ready = arb_ready[0];
    assign host_rd_valid  = arb_rd_valid[0];
    assign host_rd_data   = rd_word;

    operand_bank u_bank
    (
        .clk     (clk),
        .rst     (rst),
        .en      (bank_en),
        .req     (bank_req),
        .rd_data (bank_rd_data)
    );

    bank_arbiter u_arb
    (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (arb_valid),
        .req          (arb_req),
        .req_ready    (arb_ready),
        .rd_valid     (arb_rd_valid),
        .rd_data      (rd_word),
        .bank_en      (bank_en),
        .bank_req     (bank_req),
        .bank_rd_data (bank_rd_data)
    );

    mod_lane u_lane0
    (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd0_valid),
        .cmd        (cmd0),
        .cmd_ready  (cmd0_ready),
        .req_valid  (arb_valid[1]),
        .req        (arb_req[1]),
        .req_ready  (arb_ready[1]),
        .rd_valid   (arb_rd_valid[1]),
        .rd_data    (rd_word),
        .done_valid (done0_valid),
        .done_dst   (done0_dst),
        .done_ready (done0_ready)
    );

    mod_lane u_lane1
    (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd1_valid),
        .cmd        (cmd1),
        .cmd_ready  (cmd1_ready),
        .req_valid  (arb_valid[2]),
        .req        (arb_req[2]),
        .req_ready  (arb_ready[2]),
        .rd_valid   (arb_rd_valid[2]),
        .rd_data    (rd_word),
        .done_valid (done1_valid),
        .done_dst   (done1_dst),
        .done_ready (done1_ready)
    );

endmodule

`default_nettype wire

//--- verilog/mod_lane.sv
// Compute lane; takes one command, fetches its operands, runs the engine and writes back
`timescale 1ns/1ps
`default_nettype none

module mod_lane
    import ma_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cmd_valid,
    input  ma_cmd_t   cmd,
    output logic      cmd_ready,
    output logic      req_valid,    // Bank request to the arbiter
    output bank_req_t req,
    input  logic      req_ready,
    input  logic      rd_valid,
    input  ma_word_t  rd_data,
    output logic      done_valid,
    output ma_addr_t  done_dst,
    input  logic      done_ready
);

    lane_state_e state;
    ma_cmd_t     cmd_q;       // Command in flight
    logic        wait_rd;     // Read granted, data due
    ma_word_t    opa;
    ma_word_t    opb;
    ma_word_t    opm;
    logic        eng_start;
    logic        eng_done;
    ma_word_t    eng_result;
    logic        is_read;

    assign is_read = (state == LANE_RD_A) || (state == LANE_RD_B) || (state == LANE_RD_M);

    ////////////////////
    // Bank request

    always_comb
    begin
        req.we    = (state == LANE_WB);
        req.wdata = eng_result;             // Only used by the write
        case (state)
            LANE_RD_A: req.addr = cmd_q.src_a;
            LANE_RD_B: req.addr = cmd_q.src_b;
            LANE_RD_M: req.addr = cmd_q.src_m;
            default:   req.addr = cmd_q.dst;
        endcase
    end

    assign req_valid  = (is_read && !wait_rd) || (state == LANE_WB);
    assign cmd_ready  = (state == LANE_IDLE);
    assign done_valid = (state == LANE_DONE);
    assign done_dst   = cmd_q.dst;

    ////////////////////
    // Sequencer

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= LANE_IDLE;
            wait_rd   <= 1'b0;
            eng_start <= 1'b0;
        end
        else
        begin
            eng_start <= 1'b0;
            if (is_read && req_valid && req_ready)
                wait_rd <= 1'b1;            // Data comes next cycle
            case (state)
                LANE_IDLE:
                    if (cmd_valid)
                        state <= LANE_RD_A;
                LANE_RD_A:
                    if (wait_rd && rd_valid)
                    begin
                        wait_rd <= 1'b0;
                        state   <= LANE_RD_B;
                    end
                LANE_RD_B:
                    if (wait_rd && rd_valid)
                    begin
                        wait_rd <= 1'b0;
                        state   <= LANE_RD_M;
                    end
                LANE_RD_M:
                    if (wait_rd && rd_valid)
                    begin
                        wait_rd   <= 1'b0;
                        eng_start <= 1'b1;  // All three words in hand
                        state     <= LANE_RUN;
                    end
                LANE_RUN:
                    if (eng_done)
                        state <= LANE_WB;
                LANE_WB:
                    if (req_ready)
                        state <= LANE_DONE;
                LANE_DONE:
                    if (done_ready)
                        state <= LANE_IDLE;
                default:
                    state <= LANE_IDLE;
            endcase
        end
    end

    // Command and operand capture
    always_ff @(posedge clk)
    begin
        if (state == LANE_IDLE && cmd_valid)
            cmd_q <= cmd;
        if (wait_rd && rd_valid)
        begin
            case (state)
                LANE_RD_A: opa <= rd_data;
                LANE_RD_B: opb <= rd_data;
                default:   opm <= rd_data;
            endcase
        end
    end

    mod_add_engine u_engine
    (
        .clk    (clk),
        .rst    (rst),
        .start  (eng_start),
        .op     (cmd_q.op),
        .op1    (opa),
        .op2    (opb),
        .mod    (opm),
        .result (eng_result),
        .done   (eng_done)
    );

endmodule

`default_nettype wire

//--- verilog/operand_bank.sv
// Single-port operand memory; one access per enabled cycle, read data one cycle later
`timescale 1ns/1ps
`default_nettype none

`include "ma_cfg.svh"

module operand_bank
    import ma_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      en,        // Access this cycle
    input  bank_req_t req,
    output ma_word_t  rd_data    // Valid the cycle after a read
);

    ma_word_t mem [`MA_DEPTH];   // Word storage

    // Write port
    always_ff @(posedge clk)
    begin
        if (en && req.we)
            mem[req.addr] <= req.wdata;
    end

    // Registered read port
    always_ff @(posedge clk)
    begin
        if (rst)
            rd_data <= '0;
        else if (en && !req.we)
            rd_data <= mem[req.addr];
    end

endmodule

`default_nettype wire
